/* design/exePkg.sv */
package exePkg;

    localparam int DataWidth  = 32;
    localparam int ProdWidth  = 64;   // HI/LO pair
    localparam int IterCount  = 32;
    localparam int CountWidth = 5;

    // execute opcodes with codes above OpMflo undefined
    typedef enum logic [4:0] {
        OpNop   = 5'd0,   // passes A
        OpAnd,
        OpOr,
        OpNor,
        OpXor,
        OpAdd,
        OpAddu,
        OpSub,
        OpSubu,
        OpSlt,
        OpSltu,
        OpSllv,
        OpSrlv,
        OpSrav,
        OpSll,
        OpSrl,
        OpSra,
        OpLui,
        OpMult,
        OpMultu,
        OpDiv,
        OpDivu,
        OpMthi,
        OpMtlo,
        OpMfhi,
        OpMflo
    } aluOp_e;

    // multiply/divide controller
    typedef enum logic [1:0] {
        MdIdle,
        MdMul,
        MdDiv,
        MdDone
    } mdState_e;

endpackage

/* design/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
    input  exePkg::aluOp_e               opCode_i,
    input  logic [exePkg::DataWidth-1:0] srcA_i,
    input  logic [exePkg::DataWidth-1:0] srcB_i,
    input  logic [4:0]                   sa_i,
    input  logic [exePkg::DataWidth-1:0] hi_i,
    input  logic [exePkg::DataWidth-1:0] lo_i,
    output logic [exePkg::DataWidth-1:0] result_o,
    output logic                         overflow_o
);

    logic [exePkg::DataWidth-1:0] sum;
    logic [exePkg::DataWidth-1:0] diff;
    logic                         signA;
    logic                         signB;
    logic                         addOvf;
    logic                         subOvf;

    assign sum   = srcA_i + srcB_i;
    assign diff  = srcA_i - srcB_i;
    assign signA = srcA_i[exePkg::DataWidth-1];
    assign signB = srcB_i[exePkg::DataWidth-1];

    // same signs in, different sign out
    assign addOvf = (signA == signB) && (sum[exePkg::DataWidth-1] != signA);
    // signs differ and result follows B
    assign subOvf = (signA != signB) && (diff[exePkg::DataWidth-1] == signB);

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (opCode_i)
            exePkg::OpNop:   result_o = srcA_i;
            exePkg::OpAnd:   result_o = srcA_i & srcB_i;
            exePkg::OpOr:    result_o = srcA_i | srcB_i;
            exePkg::OpNor:   result_o = ~(srcA_i | srcB_i);
            exePkg::OpXor:   result_o = srcA_i ^ srcB_i;

            exePkg::OpAdd: begin
                result_o   = sum;
                overflow_o = addOvf;
            end
            exePkg::OpAddu:  result_o = sum;   // never flags
            exePkg::OpSub: begin
                result_o   = diff;
                overflow_o = subOvf;
            end
            exePkg::OpSubu:  result_o = diff;

            exePkg::OpSlt:   result_o[0] = $signed(srcA_i) < $signed(srcB_i);
            exePkg::OpSltu:  result_o[0] = srcA_i < srcB_i;

            // variable shifts take the amount from A
            exePkg::OpSllv:  result_o = srcB_i << srcA_i[4:0];
            exePkg::OpSrlv:  result_o = srcB_i >> srcA_i[4:0];
            exePkg::OpSrav:  result_o = $signed(srcB_i) >>> srcA_i[4:0];
            exePkg::OpSll:   result_o = srcB_i << sa_i;
            exePkg::OpSrl:   result_o = srcB_i >> sa_i;
            exePkg::OpSra:   result_o = $signed(srcB_i) >>> sa_i;

            exePkg::OpLui:   result_o = {srcB_i[15:0], 16'h0000};

            // iterative ops report through the controller
            exePkg::OpMult,
            exePkg::OpMultu,
            exePkg::OpDiv,
            exePkg::OpDivu:  result_o = '0;

            exePkg::OpMthi,
            exePkg::OpMtlo:  result_o = srcA_i;   // echo written word
            exePkg::OpMfhi:  result_o = hi_i;
            exePkg::OpMflo:  result_o = lo_i;

            default:         result_o = '0;
        endcase
    end

endmodule

/* design/mulDivCtrl.sv */
`timescale 1ns/1ps

module mulDivCtrl (
    input  logic           clk_i,
    input  logic           rstN_i,
    input  logic           flush_i,
    input  logic           start_i,
    input  exePkg::aluOp_e opCode_i,
    input  logic           last_i,
    input  logic           accept_i,
    output logic           mulLoad_o,
    output logic           divLoad_o,
    output logic           signed_o,
    output logic           step_o,
    output logic           cntClear_o,
    output logic           busy_o,
    output logic           done_o
);

    exePkg::mdState_e state_q;
    exePkg::mdState_e stateNext;
    logic             isMul;
    logic             isDiv;
    logic             launch;

    assign isMul  = (opCode_i == exePkg::OpMult) || (opCode_i == exePkg::OpMultu);
    assign isDiv  = (opCode_i == exePkg::OpDiv) || (opCode_i == exePkg::OpDivu);
    assign launch = start_i && (state_q == exePkg::MdIdle);

    always_comb begin
        stateNext = state_q;
        case (state_q)
            exePkg::MdIdle: begin
                if (launch && isMul) stateNext = exePkg::MdMul;
                else if (launch && isDiv) stateNext = exePkg::MdDiv;
            end
            exePkg::MdMul,
            exePkg::MdDiv:  if (last_i) stateNext = exePkg::MdDone;
            exePkg::MdDone: if (accept_i) stateNext = exePkg::MdIdle;   // waits on output
            default:        stateNext = exePkg::MdIdle;
        endcase
        if (flush_i) stateNext = exePkg::MdIdle;
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) state_q <= exePkg::MdIdle;
        else state_q <= stateNext;
    end

    // operands are only there on the accepting edge
    assign mulLoad_o  = launch && isMul;
    assign divLoad_o  = launch && isDiv;
    assign cntClear_o = launch && (isMul || isDiv);
    assign signed_o   = (opCode_i == exePkg::OpMult) || (opCode_i == exePkg::OpDiv);

    assign step_o = (state_q == exePkg::MdMul) || (state_q == exePkg::MdDiv);
    assign busy_o = state_q != exePkg::MdIdle;
    assign done_o = state_q == exePkg::MdDone;

endmodule

/* design/iterCounter.sv */
`timescale 1ns/1ps

module iterCounter (
    input  logic clk_i,
    input  logic rstN_i,
    input  logic clear_i,
    input  logic step_i,
    output logic last_o
);

    logic [exePkg::CountWidth-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (step_i) begin
            count_q <= count_q + 1'b1;   // wraps after the final step
        end
    end

    // high during the final step, not after it
    assign last_o = step_i && (count_q == exePkg::CountWidth'(exePkg::IterCount - 1));

endmodule

/* design/seqMul.sv */
`timescale 1ns/1ps

module seqMul (
    input  logic                         clk_i,
    input  logic                         load_i,
    input  logic                         step_i,
    input  logic                         signed_i,
    input  logic [exePkg::DataWidth-1:0] srcA_i,
    input  logic [exePkg::DataWidth-1:0] srcB_i,
    output logic [exePkg::ProdWidth-1:0] product_o
);

    logic [exePkg::ProdWidth-1:0] mcand_q;
    logic [exePkg::DataWidth-1:0] mplier_q;
    logic [exePkg::ProdWidth-1:0] acc_q;
    logic                         negRes_q;
    logic                         signA;
    logic                         signB;
    logic [exePkg::DataWidth-1:0] magA;
    logic [exePkg::DataWidth-1:0] magB;

    assign signA = signed_i && srcA_i[exePkg::DataWidth-1];
    assign signB = signed_i && srcB_i[exePkg::DataWidth-1];
    assign magA  = signA ? -srcA_i : srcA_i;   // 0x80000000 stays as its own magnitude
    assign magB  = signB ? -srcB_i : srcB_i;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            mcand_q  <= {{(exePkg::ProdWidth - exePkg::DataWidth){1'b0}}, magA};
            mplier_q <= magB;
            acc_q    <= '0;
            negRes_q <= signA ^ signB;
        end else if (step_i) begin
            // one multiplier bit per step
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product_o = negRes_q ? -acc_q : acc_q;

endmodule

/* design/seqDiv.sv */
`timescale 1ns/1ps

module seqDiv (
    input  logic                         clk_i,
    input  logic                         load_i,
    input  logic                         step_i,
    input  logic                         signed_i,
    input  logic [exePkg::DataWidth-1:0] srcA_i,
    input  logic [exePkg::DataWidth-1:0] srcB_i,
    output logic [exePkg::ProdWidth-1:0] quotRem_o
);

    logic [exePkg::DataWidth-1:0] rem_q;
    logic [exePkg::DataWidth-1:0] quot_q;     // dividend shifts out as quotient shifts in
    logic [exePkg::DataWidth-1:0] divisor_q;
    logic                         negQ_q;
    logic                         negR_q;
    logic                         divZero_q;
    logic                         signA;
    logic                         signB;
    logic [exePkg::DataWidth-1:0] magA;
    logic [exePkg::DataWidth-1:0] magB;
    logic [exePkg::DataWidth:0]   shifted;
    logic [exePkg::DataWidth+1:0] trial;
    logic [exePkg::DataWidth-1:0] quotient;
    logic [exePkg::DataWidth-1:0] remainder;

    assign signA = signed_i && srcA_i[exePkg::DataWidth-1];
    assign signB = signed_i && srcB_i[exePkg::DataWidth-1];
    assign magA  = signA ? -srcA_i : srcA_i;
    assign magB  = signB ? -srcB_i : srcB_i;

    assign shifted = {rem_q, quot_q[exePkg::DataWidth-1]};
    assign trial   = {1'b0, shifted} - {2'b00, divisor_q};

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            rem_q     <= '0;
            quot_q    <= magA;
            divisor_q <= magB;
            negQ_q    <= signA ^ signB;
            negR_q    <= signA;                  // remainder follows dividend
            divZero_q <= srcB_i == '0;
        end else if (step_i) begin
            if (!trial[exePkg::DataWidth+1]) begin
                rem_q  <= trial[exePkg::DataWidth-1:0];
                quot_q <= {quot_q[exePkg::DataWidth-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[exePkg::DataWidth-1:0];   // restore
                quot_q <= {quot_q[exePkg::DataWidth-2:0], 1'b0};
            end
        end
    end

    // zero divisor leaves |A| in rem_q, so the sign fix gives back A
    assign quotient  = divZero_q ? '1 : (negQ_q ? -quot_q : quot_q);
    assign remainder = negR_q ? -rem_q : rem_q;
    assign quotRem_o = {remainder, quotient};

endmodule

/* design/hiloReg.sv */
`timescale 1ns/1ps

module hiloReg (
    input  logic                         clk_i,
    input  logic                         rstN_i,
    input  logic                         wrPair_i,
    input  logic [exePkg::ProdWidth-1:0] pair_i,
    input  logic                         wrHi_i,
    input  logic                         wrLo_i,
    input  logic [exePkg::DataWidth-1:0] word_i,
    output logic [exePkg::DataWidth-1:0] hi_o,
    output logic [exePkg::DataWidth-1:0] lo_o
);

    logic [exePkg::DataWidth-1:0] hi_q;
    logic [exePkg::DataWidth-1:0] lo_q;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (wrPair_i) begin
            // mul/div result beats a half write
            hi_q <= pair_i[exePkg::ProdWidth-1:exePkg::DataWidth];
            lo_q <= pair_i[exePkg::DataWidth-1:0];
        end else begin
            if (wrHi_i) hi_q <= word_i;
            if (wrLo_i) lo_q <= word_i;
        end
    end

    assign hi_o = hi_q;
    assign lo_o = lo_q;

endmodule

/* design/exeUnit.sv */
`timescale 1ns/1ps

module exeUnit (
    input  logic                         clk_i,
    input  logic                         rstN_i,
    input  logic                         flush_i,
    input  logic                         opValid_i,
    output logic                         opReady_o,
    input  exePkg::aluOp_e               opCode_i,
    input  logic [exePkg::DataWidth-1:0] srcA_i,
    input  logic [exePkg::DataWidth-1:0] srcB_i,
    input  logic [4:0]                   sa_i,
    output logic                         resValid_o,
    input  logic                         resReady_i,
    output logic [exePkg::DataWidth-1:0] result_o,
    output logic                         overflow_o
);

    logic [exePkg::DataWidth-1:0] aluResult;
    logic [exePkg::DataWidth-1:0] hi;
    logic [exePkg::DataWidth-1:0] lo;
    logic [exePkg::ProdWidth-1:0] product;
    logic [exePkg::ProdWidth-1:0] quotRem;
    logic [exePkg::ProdWidth-1:0] mdResult;
    logic [exePkg::DataWidth-1:0] result_q;
    logic                         aluOvf;
    logic                         outFree;
    logic                         accept;
    logic                         isMd;
    logic                         aluFire;
    logic                         mdWrite;
    logic                         mulLoad;
    logic                         divLoad;
    logic                         mdSigned;
    logic                         step;
    logic                         cntClear;
    logic                         busy;
    logic                         done;
    logic                         last;
    logic                         mdIsDiv_q;
    logic                         resValid_q;
    logic                         overflow_q;

    assign outFree   = !resValid_q || resReady_i;   // empty or draining now
    assign opReady_o = !busy && outFree;
    assign accept    = opValid_i && opReady_o;
    assign isMd      = opCode_i inside {exePkg::OpMult, exePkg::OpMultu,
                                        exePkg::OpDiv, exePkg::OpDivu};
    assign aluFire   = accept && !isMd && !flush_i;
    assign mdWrite   = done && outFree && !flush_i;
    assign mdResult  = mdIsDiv_q ? quotRem : product;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) mdIsDiv_q <= 1'b0;
        else if (accept && isMd) mdIsDiv_q <= opCode_i inside {exePkg::OpDiv, exePkg::OpDivu};
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i || flush_i) resValid_q <= 1'b0;
        else if (aluFire || mdWrite) resValid_q <= 1'b1;
        else if (resReady_i) resValid_q <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (aluFire) begin
            result_q   <= aluResult;
            overflow_q <= aluOvf;
        end else if (mdWrite) begin
            result_q   <= mdResult[exePkg::DataWidth-1:0];   // LO
            overflow_q <= 1'b0;
        end
    end

    assign resValid_o = resValid_q;
    assign result_o   = result_q;
    assign overflow_o = overflow_q;

    aluCore aluCore_i (.opCode_i(opCode_i), .srcA_i(srcA_i), .srcB_i(srcB_i), .sa_i(sa_i),
        .hi_i(hi), .lo_i(lo), .result_o(aluResult), .overflow_o(aluOvf));

    mulDivCtrl mulDivCtrl_i (.clk_i(clk_i), .rstN_i(rstN_i), .flush_i(flush_i),
        .start_i(accept), .opCode_i(opCode_i), .last_i(last), .accept_i(mdWrite),
        .mulLoad_o(mulLoad), .divLoad_o(divLoad), .signed_o(mdSigned), .step_o(step),
        .cntClear_o(cntClear), .busy_o(busy), .done_o(done));

    iterCounter iterCounter_i (.clk_i(clk_i), .rstN_i(rstN_i), .clear_i(cntClear),
        .step_i(step), .last_o(last));

    seqMul seqMul_i (.clk_i(clk_i), .load_i(mulLoad), .step_i(step && !mdIsDiv_q),
        .signed_i(mdSigned), .srcA_i(srcA_i), .srcB_i(srcB_i), .product_o(product));

    seqDiv seqDiv_i (.clk_i(clk_i), .load_i(divLoad), .step_i(step && mdIsDiv_q),
        .signed_i(mdSigned), .srcA_i(srcA_i), .srcB_i(srcB_i), .quotRem_o(quotRem));

    hiloReg hiloReg_i (.clk_i(clk_i), .rstN_i(rstN_i), .wrPair_i(mdWrite), .pair_i(mdResult),
        .wrHi_i(aluFire && (opCode_i == exePkg::OpMthi)),
        .wrLo_i(aluFire && (opCode_i == exePkg::OpMtlo)),
        .word_i(srcA_i), .hi_o(hi), .lo_o(lo));

endmodule

/* verif/exeUnitTb.sv */
`timescale 1ns/1ps

module exeUnitTb;

    localparam int OpTimeout = 60;   // cycles to wait for opReady
    localparam int MdLatency = 50;

    logic           clk = 1'b0;
    logic           rstN;
    logic           flush;
    logic           opValid;
    logic           opReady;
    exePkg::aluOp_e opCode;
    logic [31:0]    srcA;
    logic [31:0]    srcB;
    logic [4:0]     sa;
    logic           resValid;
    logic           resReady;
    logic [31:0]    result;
    logic           overflow;
    logic [31:0]    modelHi;
    logic [31:0]    modelLo;
    logic [31:0]    pairA [12];
    logic [31:0]    pairB [12];

    exeUnit exeUnit_i (
        .clk_i(clk), .rstN_i(rstN), .flush_i(flush),
        .opValid_i(opValid), .opReady_o(opReady), .opCode_i(opCode),
        .srcA_i(srcA), .srcB_i(srcB), .sa_i(sa),
        .resValid_o(resValid), .resReady_i(resReady),
        .result_o(result), .overflow_o(overflow)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            abortRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    // single-cycle ops with HI/LO taken from the model pair
    function automatic logic [31:0] aluModel(input exePkg::aluOp_e op, input logic [31:0] a,
                                             input logic [31:0] b, input logic [4:0] amt,
                                             output logic ovf);
        longint     wide;
        logic [63:0] ext;
        ovf = 1'b0;
        case (op)
            exePkg::OpNop:  return a;
            exePkg::OpAnd:  return a & b;
            exePkg::OpOr:   return a | b;
            exePkg::OpNor:  return ~(a | b);
            exePkg::OpXor:  return a ^ b;
            exePkg::OpAdd: begin
                wide = longint'($signed(a)) + longint'($signed(b));
                ovf  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
                return a + b;
            end
            exePkg::OpAddu: return a + b;
            exePkg::OpSub: begin
                wide = longint'($signed(a)) - longint'($signed(b));
                ovf  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
                return a - b;
            end
            exePkg::OpSubu: return a - b;
            exePkg::OpSlt:  return {31'b0, $signed(a) < $signed(b)};
            exePkg::OpSltu: return {31'b0, a < b};
            exePkg::OpSllv: return b << a[4:0];
            exePkg::OpSrlv: return b >> a[4:0];
            exePkg::OpSrav: begin
                ext = {{32{b[31]}}, b} >> a[4:0];   // sign fill from the top half
                return ext[31:0];
            end
            exePkg::OpSll:  return b << amt;
            exePkg::OpSrl:  return b >> amt;
            exePkg::OpSra: begin
                ext = {{32{b[31]}}, b} >> amt;
                return ext[31:0];
            end
            exePkg::OpLui:  return {b[15:0], 16'h0000};
            exePkg::OpMthi, exePkg::OpMtlo: return a;
            exePkg::OpMfhi: return modelHi;
            exePkg::OpMflo: return modelLo;
            default:        return '0;
        endcase
    endfunction

    // {HI, LO} after a multiply or divide
    function automatic logic [63:0] mulDivModel(input exePkg::aluOp_e op, input logic [31:0] a,
                                                input logic [31:0] b);
        longint dividend;
        longint divisor;
        if (op == exePkg::OpMult) return longint'($signed(a)) * longint'($signed(b));
        if (op == exePkg::OpMultu) return {32'b0, a} * {32'b0, b};
        if (b == 0) return {a, 32'hffff_ffff};
        if (op == exePkg::OpDivu) return {a % b, a / b};
        dividend = $signed(a);
        divisor  = $signed(b);
        return {32'(dividend % divisor), 32'(dividend / divisor)};
    endfunction

    task automatic sendOp(input exePkg::aluOp_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] amt);
        int waited;
        waited  = 0;
        opValid = 1'b1;
        opCode  = op;
        srcA    = a;
        srcB    = b;
        sa      = amt;
        @(negedge clk);
        while (!opReady) begin
            if (waited >= OpTimeout) abortRun("timeout: opReady_o stayed low, op never accepted");
            else begin
                waited++;
                @(negedge clk);
            end
        end
        @(posedge clk);   // accepting edge
        #2;
        opValid = 1'b0;
    endtask

    task automatic recvResult(input int limit, input int hold, output logic [31:0] res,
                              output logic ovf);
        int waited;
        waited   = 0;
        resReady = (hold == 0);
        @(negedge clk);
        while (!resValid) begin
            if (waited >= limit) abortRun($sformatf("no result within %0d cycles", limit + 1));
            else begin
                waited++;
                @(negedge clk);
            end
        end
        res = result;
        ovf = overflow;
        for (int i = 0; i < hold; i++) begin
            checkVal("opReady_o while output full", opReady, 1'b0);
            checkVal("held resValid_o", resValid, 1'b1);
            checkVal("held result_o", result, res);
            @(negedge clk);
        end
        if (hold > 0) begin
            @(posedge clk);
            #2;
            resReady = 1'b1;
        end
        @(posedge clk);   // entry taken here
        #2;
        @(negedge clk);
        checkVal("resValid_o after hand-off", resValid, 1'b0);   // no duplicate
        @(posedge clk);
        #2;
    endtask

    task automatic runOp(input exePkg::aluOp_e op, input logic [31:0] a, input logic [31:0] b,
                         input logic [4:0] amt, input int hold);
        logic [31:0] expRes;
        logic        expOvf;
        logic [63:0] expPair;
        logic [31:0] gotRes;
        logic        gotOvf;
        bit          isMd;
        isMd = op inside {exePkg::OpMult, exePkg::OpMultu, exePkg::OpDiv, exePkg::OpDivu};
        if (isMd) begin
            expPair = mulDivModel(op, a, b);
            expRes  = expPair[31:0];   // result port returns LO
            expOvf  = 1'b0;
        end else begin
            expRes = aluModel(op, a, b, amt, expOvf);
        end
        sendOp(op, a, b, amt);
        recvResult(isMd ? MdLatency : 0, hold, gotRes, gotOvf);
        checkVal($sformatf("op %0d result for %h, %h", op, a, b), gotRes, expRes);
        checkVal($sformatf("op %0d overflow for %h, %h", op, a, b), gotOvf, expOvf);
        if (isMd) begin
            modelHi = expPair[63:32];
            modelLo = expPair[31:0];
        end else if (op == exePkg::OpMthi) begin
            modelHi = a;
        end else if (op == exePkg::OpMtlo) begin
            modelLo = a;
        end
    endtask

    task automatic hiLoMoves();
        runOp(exePkg::OpMfhi, 32'h0, 32'h0, 5'd0, 0);   // zero after reset
        runOp(exePkg::OpMflo, 32'h0, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMthi, $urandom, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMfhi, 32'h0, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMflo, 32'h0, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMtlo, $urandom, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMfhi, 32'h0, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMflo, 32'h0, 32'h0, 5'd0, 0);
    endtask

    task automatic singleCycleOps();
        for (int p = 0; p < 12; p++) begin
            for (int k = 0; k <= int'(exePkg::OpLui); k++) begin
                runOp(exePkg::aluOp_e'(k), pairA[p], pairB[p], 5'($urandom), 0);
            end
        end
        runOp(exePkg::aluOp_e'(5'd29), 32'h1234_5678, 32'h1, 5'd3, 0);   // undefined code
    endtask

    task automatic mulDivOps();
        for (int k = int'(exePkg::OpMult); k <= int'(exePkg::OpDivu); k++) begin
            for (int p = 0; p < 12; p++) begin
                runOp(exePkg::aluOp_e'(k), pairA[p], pairB[p], 5'd0, 0);
                runOp(exePkg::OpMfhi, $urandom, 32'h0, 5'd0, 0);
                runOp(exePkg::OpMflo, $urandom, 32'h0, 5'd0, 0);
            end
        end
    endtask

    task automatic outputBackPressure();
        for (int n = 0; n < 8; n++) begin
            runOp(exePkg::aluOp_e'(5'($urandom % 18)), $urandom, $urandom, 5'($urandom),
                  1 + $urandom % 6);
        end
        runOp(exePkg::OpMult, $urandom, $urandom, 5'd0, 1 + $urandom % 6);   // LO held at output
        runOp(exePkg::OpMfhi, 32'h0, 32'h0, 5'd0, 1 + $urandom % 6);
    endtask

    task automatic flushDuringDivide();
        runOp(exePkg::OpMthi, $urandom, 32'h0, 5'd0, 0);
        runOp(exePkg::OpMtlo, $urandom, 32'h0, 5'd0, 0);
        sendOp(exePkg::OpDiv, 32'h0001_0000, 32'h7, 5'd0);
        repeat (2 + $urandom % 20) @(posedge clk);   // divide still stepping
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        for (int c = 0; c < MdLatency; c++) begin
            @(negedge clk);
            checkVal("resValid_o after flushed divide", resValid, 1'b0);
        end
        @(posedge clk);
        #2;
        runOp(exePkg::OpMfhi, 32'h0, 32'h0, 5'd0, 0);   // HI/LO kept
        runOp(exePkg::OpMflo, 32'h0, 32'h0, 5'd0, 0);

        // a waiting output entry is dropped too
        resReady = 1'b0;
        sendOp(exePkg::OpAdd, 32'h1, 32'h2, 5'd0);
        flush = 1'b1;
        @(negedge clk);
        checkVal("resValid_o before flush edge", resValid, 1'b1);
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        checkVal("resValid_o after flush", resValid, 1'b0);
        checkVal("opReady_o after flush", opReady, 1'b1);
        @(posedge clk);
        #2;
        resReady = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h4016));
        rstN     = 1'b0;
        flush    = 1'b0;
        opValid  = 1'b0;
        opCode   = exePkg::OpNop;
        srcA     = '0;
        srcB     = '0;
        sa       = '0;
        resReady = 1'b1;
        modelHi  = '0;
        modelLo  = '0;
        pairA = '{32'h0, 32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff,
                  32'hffff_fff9, 32'hffff_ff9c, 32'h64, 32'h64, 32'hffff_cfc7,
                  $urandom, $urandom};
        pairB = '{32'h0, 32'h1, 32'hffff_ffff, 32'h1, 32'h8000_0000,
                  32'h9, 32'hffff_fff9, 32'hffff_fff9, 32'h0, 32'h0,
                  $urandom, $urandom};
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(negedge clk);
        checkVal("resValid_o after reset", resValid, 1'b0);
        checkVal("opReady_o after reset", opReady, 1'b1);
        @(posedge clk);
        #2;
        hiLoMoves();
        singleCycleOps();
        mulDivOps();
        outputBackPressure();
        flushDuringDivide();
        $display("No errors");
        $finish;
    end

endmodule

/* build.f */
design/exePkg.sv
design/aluCore.sv
design/mulDivCtrl.sv
design/iterCounter.sv
design/seqMul.sv
design/seqDiv.sv
design/hiloReg.sv
design/exeUnit.sv
verif/exeUnitTb.sv
